/* logic/isa_pkg.sv */
// Instruction encodings and field helpers, shared by the decoder, execute and the testbench model
`default_nettype none

package isa_pkg;

	// Data and instruction words
	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;

	// Instruction fields
	typedef logic [2:0] reg_idx_t;
	typedef logic [4:0] opcode_t;
	typedef logic [1:0] funct_t;
	typedef logic [4:0] imm5_t;
	typedef logic [7:0] imm8_t;

	// Opcodes, bits 15 to 11
	localparam opcode_t OP_HALT  = 5'b00000;
	localparam opcode_t OP_NOP   = 5'b00001;
	localparam opcode_t OP_ADDI  = 5'b01000;
	localparam opcode_t OP_SUBI  = 5'b01001;
	localparam opcode_t OP_XORI  = 5'b01010;
	localparam opcode_t OP_ANDNI = 5'b01011;
	localparam opcode_t OP_LBI   = 5'b11000;
	localparam opcode_t OP_ALU_R = 5'b11011;

	// Function field of the register ALU group
	localparam funct_t FN_ADD  = 2'b00;
	localparam funct_t FN_SUB  = 2'b01;
	localparam funct_t FN_XOR  = 2'b10;
	localparam funct_t FN_ANDN = 2'b11;

	// Bubble word fed into decode
	localparam instr_t NOP_INSTR = {OP_NOP, 11'b000_0000_0000};

	function automatic opcode_t instr_opcode(input instr_t instr);
		return instr[15:11];
	endfunction

	function automatic funct_t instr_funct(input instr_t instr);
		return instr[1:0];
	endfunction

	// Rs sits in bits 10 to 8, Rt in bits 7 to 5
	function automatic reg_idx_t instr_rs(input instr_t instr);
		return instr[10:8];
	endfunction

	function automatic reg_idx_t instr_rt(input instr_t instr);
		return instr[7:5];
	endfunction

	// Low byte, also holds the 5-bit immediate in its bottom bits
	function automatic imm8_t instr_imm8(input instr_t instr);
		return instr[7:0];
	endfunction

endpackage

`default_nettype wire

/* logic/pipe_pkg.sv */
// Pipeline sizing and state encodings, imported by the stage modules
`default_nettype none

package pipe_pkg;

	// Instruction memory inside fetch
	localparam int IMEM_DEPTH = 256;
	localparam int PC_W       = $clog2(IMEM_DEPTH);

	// Register file size
	localparam int NUM_REGS = 8;

	// Word address into the instruction memory
	typedef logic [PC_W-1:0] pc_t;

	// Operation carried from decode into execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS_B
	} alu_op_t;

	// Fetch FSM
	typedef enum logic [1:0] {
		FS_IDLE,
		FS_RUN,
		FS_HALT
	} fetch_state_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
// Fetch stage holding the PC, the loadable instruction memory and the fetch/decode register
`default_nettype none

module fetch_stage (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    run,
	input  wire                    halt_seen,
	input  wire                    imem_we,
	input  wire pipe_pkg::pc_t     imem_addr,
	input  wire isa_pkg::instr_t   imem_data,
	output isa_pkg::instr_t        fd_instr
);
	import isa_pkg::*;
	import pipe_pkg::*;

	fetch_state_t state;
	pc_t          pc;

	instr_t imem [IMEM_DEPTH];

	// Program load, only while the pipe is idle
	always_ff @(posedge clk) begin
		if (imem_we && state == FS_IDLE) begin
			imem[imem_addr] <= imem_data;
		end
	end

	// One instruction per running cycle, bubbles otherwise
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= FS_IDLE;
			pc       <= '0;
			fd_instr <= NOP_INSTR;
		end else begin
			case (state)
				FS_IDLE: begin
					fd_instr <= NOP_INSTR;
					pc       <= '0;
					if (run) begin
						state <= FS_RUN;
					end
				end
				FS_RUN: begin
					if (halt_seen) begin
						// Squash the word behind the halt and park the PC
						state    <= FS_HALT;
						fd_instr <= NOP_INSTR;
					end else begin
						fd_instr <= imem[pc];
						pc       <= pc + 1'b1;
					end
				end
				FS_HALT: begin
					// Stays here until reset
					fd_instr <= NOP_INSTR;
				end
				default: begin
					state    <= FS_IDLE;
					fd_instr <= NOP_INSTR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/instr_decode.sv */
// Decode stage that turns opcode and function into controls and fills the decode/execute register
`default_nettype none

module instr_decode (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire isa_pkg::instr_t   fd_instr,
	input  wire isa_pkg::word_t    rd_data_a,
	input  wire isa_pkg::word_t    rd_data_b,
	output isa_pkg::reg_idx_t      rd_idx_a,
	output isa_pkg::reg_idx_t      rd_idx_b,
	output logic                   halt_seen,
	output isa_pkg::word_t         de_data_a,
	output isa_pkg::word_t         de_data_b,
	output isa_pkg::reg_idx_t      de_src_a,
	output isa_pkg::reg_idx_t      de_src_b,
	output isa_pkg::reg_idx_t      de_dest,
	output logic                   de_wr,
	output pipe_pkg::alu_op_t      de_op,
	output logic                   de_use_imm,
	output isa_pkg::imm8_t         de_imm,
	output logic                   de_lbi,
	output logic                   de_halt,
	output logic                   de_err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t  opcode;
	funct_t   alu_code;
	reg_idx_t dest;
	alu_op_t  op;
	logic     wr;
	logic     use_imm;
	logic     lbi;
	logic     halt;
	logic     err;

	assign opcode   = instr_opcode(fd_instr);
	assign rd_idx_a = instr_rs(fd_instr);
	assign rd_idx_b = instr_rt(fd_instr);

	// Fetch reacts in the same cycle
	assign halt_seen = halt;

	// Control decode
	always_comb begin
		dest    = fd_instr[4:2];
		wr      = 1'b0;
		use_imm = 1'b0;
		lbi     = 1'b0;
		halt    = 1'b0;
		err     = 1'b0;
		case (opcode)
			OP_HALT: begin
				halt = 1'b1;
			end
			OP_NOP: begin
			end
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
				dest    = fd_instr[7:5];
				wr      = 1'b1;
				use_imm = 1'b1;
			end
			OP_LBI: begin
				dest    = instr_rs(fd_instr);
				wr      = 1'b1;
				use_imm = 1'b1;
				lbi     = 1'b1;
			end
			OP_ALU_R: begin
				wr = 1'b1;
			end
			// Illegal opcode, flagged and otherwise a nop
			default: begin
				err = 1'b1;
			end
		endcase
	end

	// ALU decode, immediate group reuses the function encoding in its low opcode bits
	always_comb begin
		alu_code = (opcode == OP_ALU_R) ? instr_funct(fd_instr) : opcode[1:0];
		op       = ALU_ADD;
		if (lbi) begin
			op = ALU_PASS_B;
		end else begin
			case (alu_code)
				FN_ADD:  op = ALU_ADD;
				FN_SUB:  op = ALU_SUB;
				FN_XOR:  op = ALU_XOR;
				FN_ANDN: op = ALU_ANDN;
				default: op = ALU_ADD;
			endcase
		end
	end

	// Decode/execute register, control part
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de_wr      <= 1'b0;
			de_op      <= ALU_ADD;
			de_use_imm <= 1'b0;
			de_lbi     <= 1'b0;
			de_halt    <= 1'b0;
			de_err     <= 1'b0;
		end else begin
			de_wr      <= wr;
			de_op      <= op;
			de_use_imm <= use_imm;
			de_lbi     <= lbi;
			de_halt    <= halt;
			de_err     <= err;
		end
	end

	// Operands and fields
	always_ff @(posedge clk) begin
		de_data_a <= rd_data_a;
		de_data_b <= rd_data_b;
		de_src_a  <= rd_idx_a;
		de_src_b  <= rd_idx_b;
		de_dest   <= dest;
		de_imm    <= instr_imm8(fd_instr);
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
// Register file with two combinational read ports and write-through bypass, read in decode
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire isa_pkg::reg_idx_t   rd_idx_a,
	input  wire isa_pkg::reg_idx_t   rd_idx_b,
	input  wire                      wr_en,
	input  wire isa_pkg::reg_idx_t   wr_idx,
	input  wire isa_pkg::word_t      wr_data,
	output isa_pkg::word_t           rd_data_a,
	output isa_pkg::word_t           rd_data_b
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Same-cycle write wins over the stored value
	assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
// Execute stage with operand forwarding, immediate extension, ALU and the write-back register
`default_nettype none

module exec_stage (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire isa_pkg::word_t      de_data_a,
	input  wire isa_pkg::word_t      de_data_b,
	input  wire isa_pkg::reg_idx_t   de_src_a,
	input  wire isa_pkg::reg_idx_t   de_src_b,
	input  wire isa_pkg::reg_idx_t   de_dest,
	input  wire                      de_wr,
	input  wire pipe_pkg::alu_op_t   de_op,
	input  wire                      de_use_imm,
	input  wire isa_pkg::imm8_t      de_imm,
	input  wire                      de_lbi,
	input  wire                      de_halt,
	input  wire                      de_err,
	output logic                     wb_valid,
	output isa_pkg::reg_idx_t        wb_reg,
	output isa_pkg::word_t           wb_data,
	output logic                     halted,
	output logic                     err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t opnd_a;
	word_t fwd_b;
	word_t opnd_b;
	word_t imm_ext;
	word_t alu_out;

	// Previous instruction's result, not yet visible through the register file
	assign opnd_a = (wb_valid && wb_reg == de_src_a) ? wb_data : de_data_a;
	assign fwd_b  = (wb_valid && wb_reg == de_src_b) ? wb_data : de_data_b;

	// Add and subtract sign-extend, logic ops zero-extend
	always_comb begin
		if (de_lbi) begin
			imm_ext = {{8{de_imm[7]}}, de_imm};
		end else begin
			case (de_op)
				ALU_ADD, ALU_SUB: imm_ext = {{11{de_imm[4]}}, de_imm[4:0]};
				default:          imm_ext = {11'b0, de_imm[4:0]};
			endcase
		end
	end

	assign opnd_b = de_use_imm ? imm_ext : fwd_b;

	// Subtract is b minus a
	always_comb begin
		case (de_op)
			ALU_ADD:    alu_out = opnd_a + opnd_b;
			ALU_SUB:    alu_out = opnd_b - opnd_a;
			ALU_XOR:    alu_out = opnd_a ^ opnd_b;
			ALU_ANDN:   alu_out = opnd_a & ~opnd_b;
			ALU_PASS_B: alu_out = opnd_b;
			default:    alu_out = opnd_b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_valid <= de_wr;
			// Sticky until reset
			if (de_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= de_dest;
		wb_data <= alu_out;
	end

	// High while the illegal word sits in execute
	assign err = de_err;

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
// Processor top connecting fetch, decode, register file and execute, driven by the testbench
`default_nettype none

module cpu_top (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    run,
	input  wire                    imem_we,
	input  wire pipe_pkg::pc_t     imem_addr,
	input  wire isa_pkg::instr_t   imem_data,
	output logic                   wb_valid,
	output isa_pkg::reg_idx_t      wb_reg,
	output isa_pkg::word_t         wb_data,
	output logic                   halted,
	output logic                   err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Fetch to decode
	instr_t   fd_instr;
	logic     halt_seen;

	// Register file read side
	reg_idx_t rd_idx_a;
	reg_idx_t rd_idx_b;
	word_t    rd_data_a;
	word_t    rd_data_b;

	// Decode/execute register
	word_t    de_data_a;
	word_t    de_data_b;
	reg_idx_t de_src_a;
	reg_idx_t de_src_b;
	reg_idx_t de_dest;
	logic     de_wr;
	alu_op_t  de_op;
	logic     de_use_imm;
	imm8_t    de_imm;
	logic     de_lbi;
	logic     de_halt;
	logic     de_err;

	fetch_stage u_fetch (
		.clk       (clk),
		.arst_n    (arst_n),
		.run       (run),
		.halt_seen (halt_seen),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.fd_instr  (fd_instr)
	);

	instr_decode u_decode (
		.clk        (clk),
		.arst_n     (arst_n),
		.fd_instr   (fd_instr),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.halt_seen  (halt_seen),
		.de_data_a  (de_data_a),
		.de_data_b  (de_data_b),
		.de_src_a   (de_src_a),
		.de_src_b   (de_src_b),
		.de_dest    (de_dest),
		.de_wr      (de_wr),
		.de_op      (de_op),
		.de_use_imm (de_use_imm),
		.de_imm     (de_imm),
		.de_lbi     (de_lbi),
		.de_halt    (de_halt),
		.de_err     (de_err)
	);

	// Write port fed straight from the write-back register
	reg_file u_rf (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.wr_en     (wb_valid),
		.wr_idx    (wb_reg),
		.wr_data   (wb_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	exec_stage u_exec (
		.clk        (clk),
		.arst_n     (arst_n),
		.de_data_a  (de_data_a),
		.de_data_b  (de_data_b),
		.de_src_a   (de_src_a),
		.de_src_b   (de_src_b),
		.de_dest    (de_dest),
		.de_wr      (de_wr),
		.de_op      (de_op),
		.de_use_imm (de_use_imm),
		.de_imm     (de_imm),
		.de_lbi     (de_lbi),
		.de_halt    (de_halt),
		.de_err     (de_err),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.halted     (halted),
		.err        (err)
	);

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
// Free-running clock source for the processor testbench
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* verif/cpu_checker.sv */
// Concurrent assertions on the processor outputs, bound into cpu_top for every simulation
`default_nettype none

module cpu_checker (
	input wire clk,
	input wire arst_n,
	input wire run,
	input wire wb_valid,
	input wire halted,
	input wire err
);
	timeunit 1ns;
	timeprecision 100ps;

	// Control outputs leave reset known
	a_ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({wb_valid, err}))
		else $error("wb_valid or err is unknown");

	// Only reset clears halted
	a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		$past(halted) |-> halted)
		else $error("halted fell without a reset");

	a_quiet_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> !wb_valid)
		else $error("write-back seen while halted");

	// Pipe depth from run to the first result
	a_first_wb: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> $past(run, 3))
		else $error("write-back less than three cycles after run rose");

endmodule

bind cpu_top cpu_checker u_checker (
	.clk      (clk),
	.arst_n   (arst_n),
	.run      (run),
	.wb_valid (wb_valid),
	.halted   (halted),
	.err      (err)
);

`default_nettype wire

/* verif/cpu_tb.sv */
// Testbench top that loads a program into the processor, runs it to halt and checks the write-backs
`default_nettype none

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int NUM_ROWS    = 48;
	localparam int HALT_ROW    = 44;
	localparam int RUN_TIMEOUT = 500;

	// One program word and what it should do
	typedef struct {
		instr_t   instr;
		logic     wr;
		reg_idx_t rd;
		word_t    data;
		logic     ill;
	} row_t;

	logic     clk;
	logic     arst_n;
	logic     run;
	logic     imem_we;
	pc_t      imem_addr;
	instr_t   imem_data;
	logic     wb_valid;
	reg_idx_t wb_reg;
	word_t    wb_data;
	logic     halted;
	logic     err;

	row_t     prog [NUM_ROWS];
	int       wr_rows [$];
	int       wb_count   = 0;
	int       err_cycles = 0;

	clk_gen #(.PERIOD_NS(10)) u_clk (.clk(clk));

	cpu_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.run       (run),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.halted    (halted),
		.err       (err)
	);

	// Outputs sampled away from the active edge
	always @(negedge clk) begin
		if (arst_n) begin
			// Each write-back is checked against the next writing row
			if (wb_valid === 1'b1) begin
				if (wb_count >= wr_rows.size()) begin
					abort_run("write-back seen beyond the last expected one");
				end else begin
					compare("wb_reg", 32'(wb_reg), 32'(prog[wr_rows[wb_count]].rd));
					compare("wb_data", 32'(wb_data), 32'(prog[wr_rows[wb_count]].data));
					wb_count++;
				end
			end
			if (err === 1'b1) begin
				err_cycles++;
			end
		end
	end

	task automatic abort_run(input string reason);
		$display("ERROR at %0t ns: %s", $time, reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation stopped");
		end
	endtask

	function automatic instr_t rtype_word(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
		return {OP_ALU_R, rs, rt, rd, fn};
	endfunction

	function automatic instr_t imm_word(opcode_t op, reg_idx_t rs, reg_idx_t rd, imm5_t imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instr_t lbi_word(reg_idx_t rs, imm8_t imm);
		return {OP_LBI, rs, imm};
	endfunction

	// Mostly ALU work with some loads, nops and illegal words but no halt
	function automatic instr_t random_word();
		reg_idx_t a;
		reg_idx_t b;
		reg_idx_t c;
		int       kind;
		a    = reg_idx_t'($urandom_range(7, 0));
		b    = reg_idx_t'($urandom_range(7, 0));
		c    = reg_idx_t'($urandom_range(7, 0));
		kind = int'($urandom_range(9, 0));
		if (kind < 4) begin
			return rtype_word(funct_t'(kind), a, b, c);
		end else if (kind < 7) begin
			return imm_word(opcode_t'({3'b010, 2'($urandom)}), a, b, imm5_t'($urandom));
		end else if (kind == 7) begin
			return lbi_word(a, imm8_t'($urandom));
		end else if (kind == 8) begin
			return NOP_INSTR;
		end
		// Opcodes 10xxx are all unassigned
		return {2'b10, 14'($urandom)};
	endfunction

	task automatic build_program();
		// Dependent chain through forwarding and bypass
		prog[0].instr  = lbi_word(3'd1, 8'h85);
		prog[1].instr  = lbi_word(3'd2, 8'h12);
		prog[2].instr  = rtype_word(FN_ADD, 3'd1, 3'd2, 3'd3);
		prog[3].instr  = rtype_word(FN_SUB, 3'd3, 3'd2, 3'd4);
		prog[4].instr  = rtype_word(FN_XOR, 3'd4, 3'd1, 3'd5);
		prog[5].instr  = rtype_word(FN_ANDN, 3'd5, 3'd3, 3'd6);
		prog[6].instr  = imm_word(OP_ADDI, 3'd6, 3'd7, 5'b11101);
		prog[7].instr  = imm_word(OP_SUBI, 3'd7, 3'd1, 5'h10);
		prog[8].instr  = imm_word(OP_XORI, 3'd1, 3'd2, 5'h1f);
		prog[9].instr  = imm_word(OP_ANDNI, 3'd2, 3'd3, 5'h0a);
		prog[10].instr = 16'ha5c3;
		prog[11].instr = rtype_word(FN_ADD, 3'd3, 3'd3, 3'd0);
		for (int i = 12; i < HALT_ROW; i++) begin
			prog[i].instr = random_word();
		end
		prog[HALT_ROW].instr   = {OP_HALT, 11'h000};
		// Words behind the halt that must never write
		prog[HALT_ROW+1].instr = lbi_word(3'd1, 8'h7f);
		prog[HALT_ROW+2].instr = rtype_word(FN_ADD, 3'd1, 3'd1, 3'd2);
		prog[HALT_ROW+3].instr = imm_word(OP_ADDI, 3'd2, 3'd3, 5'h05);
	endtask

	// Reference ISA model on a shadow register file
	task automatic run_model();
		word_t    shadow [8];
		logic     stopped;
		opcode_t  op;
		reg_idx_t rs;
		word_t    a;
		word_t    b;
		word_t    sx5;
		word_t    zx5;
		stopped = 1'b0;
		for (int r = 0; r < 8; r++) begin
			shadow[r] = '0;
		end
		for (int i = 0; i < NUM_ROWS; i++) begin
			op  = prog[i].instr[15:11];
			rs  = prog[i].instr[10:8];
			a   = shadow[rs];
			b   = shadow[prog[i].instr[7:5]];
			sx5 = {{11{prog[i].instr[4]}}, prog[i].instr[4:0]};
			zx5 = {11'b0, prog[i].instr[4:0]};
			prog[i].wr   = 1'b0;
			prog[i].rd   = prog[i].instr[7:5];
			prog[i].data = '0;
			prog[i].ill  = 1'b0;
			if (!stopped) begin
				case (op)
					OP_ALU_R: begin
						prog[i].wr = 1'b1;
						prog[i].rd = prog[i].instr[4:2];
						case (prog[i].instr[1:0])
							FN_ADD:  prog[i].data = a + b;
							FN_SUB:  prog[i].data = b - a;
							FN_XOR:  prog[i].data = a ^ b;
							default: prog[i].data = a & ~b;
						endcase
					end
					OP_ADDI:  {prog[i].wr, prog[i].data} = {1'b1, a + sx5};
					OP_SUBI:  {prog[i].wr, prog[i].data} = {1'b1, sx5 - a};
					OP_XORI:  {prog[i].wr, prog[i].data} = {1'b1, a ^ zx5};
					OP_ANDNI: {prog[i].wr, prog[i].data} = {1'b1, a & ~zx5};
					OP_LBI: begin
						prog[i].wr   = 1'b1;
						prog[i].rd   = rs;
						prog[i].data = {{8{prog[i].instr[7]}}, prog[i].instr[7:0]};
					end
					OP_HALT:  stopped = 1'b1;
					OP_NOP: begin
					end
					default:  prog[i].ill = 1'b1;
				endcase
				if (prog[i].wr) begin
					shadow[prog[i].rd] = prog[i].data;
				end
			end
		end
	endtask

	// Row numbers of the writing instructions in program order
	task automatic list_writes();
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (prog[i].wr) begin
				wr_rows.push_back(i);
			end
		end
	endtask

	function automatic int illegal_count();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			n += int'(prog[i].ill);
		end
		return n;
	endfunction

	task automatic load_program();
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(posedge clk);
			imem_we   <= 1'b1;
			imem_addr <= pc_t'(i);
			imem_data <= prog[i].instr;
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	task automatic wait_halted();
		int cycles;
		cycles = 0;
		while (halted !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				abort_run("halted did not rise within the run timeout");
			end
		end
	endtask

	initial begin
		void'($urandom(32'h1f3f));
		arst_n    = 1'b0;
		run       = 1'b0;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		build_program();
		run_model();
		list_writes();
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		load_program();
		@(posedge clk);
		run <= 1'b1;
		wait_halted();
		// Everything ahead of the halt is already written back
		compare("writes before halt", wb_count, wr_rows.size());
		// Room for any write-back that leaks past the halt
		repeat (6) @(negedge clk);
		compare("err cycles", err_cycles, illegal_count());
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/cpu_top.sv
verif/clk_gen.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       := cpu_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No pass line in the log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
